/* project.f */
+incdir+verilog
verilog/field_pkg.sv
verilog/prog_pkg.sv
verilog/fexp_sched.sv
verilog/fexp_mul_unit.sv
verilog/fexp_pow_unit.sv
verilog/fexp_slots.sv
verilog/fexp_top.sv
tests/tb_clkgen.sv
tests/tb_checker.sv
tests/tb_fexp.sv

/* run.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_fexp -o sim_fexp; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_fexp)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1

/* tests/tb_fexp.sv */
`include "fexp_defines.svh"

module tb_fexp;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_FIXED      = 3;
  localparam int N_RANDOM     = 40;
  localparam int N_TESTS      = N_FIXED + N_RANDOM + 1;
  localparam int CYC_PER_TEST = 100;
  localparam int TIMEOUT_CYC  = N_TESTS * CYC_PER_TEST;

  logic               clk;
  logic               rst;
  logic               start;
  logic [`FEXP_W-1:0] x;
  int                 test_id;
  logic               busy;
  logic               done;
  logic [`FEXP_W-1:0] y;
  int                 err_cnt;
  int                 done_cnt;
  int                 pending;
  int                 end_err;
  int                 cycle_cnt;
  integer             seed;

  tb_clkgen u_clkgen (
    .o_clk (clk),
    .o_rst (rst)
  );

  fexp_top UUT (
    .i_clk   (clk),
    .i_rst   (rst),
    .i_start (start),
    .i_x     (x),
    .o_busy  (busy),
    .o_done  (done),
    .o_y     (y)
  );

  tb_checker u_checker (
    .i_clk      (clk),
    .i_rst      (rst),
    .i_start    (start),
    .i_x        (x),
    .i_test_id  (test_id),
    .i_busy     (busy),
    .i_done     (done),
    .i_y        (y),
    .o_err_cnt  (err_cnt),
    .o_done_cnt (done_cnt),
    .o_pending  (pending)
  );

  // Called on a falling edge, holds start for one cycle
  task automatic pulse_start(input int id, input logic [`FEXP_W-1:0] xv);
    start   = 1'b1;
    x       = xv;
    test_id = id;
    @(negedge clk);
    start = 1'b0;
    x     = '0;
  endtask

  task automatic wait_done_count(input int target);
    while (done_cnt < target)
      @(negedge clk);
  endtask

  task automatic run_one(input int id, input logic [`FEXP_W-1:0] xv);
    int target;
    target = done_cnt + 1;
    pulse_start(id, xv);
    wait_done_count(target);
  endtask

  initial begin
    int                 target;
    logic [`FEXP_W-1:0] xv;
    seed    = 32'h8dcb_438d;
    start   = 1'b0;
    x       = '0;
    test_id = 0;
    end_err = 0;
    @(negedge clk);
    while (rst)
      @(negedge clk);
    // Idle window after reset
    repeat (8) @(negedge clk);

    run_one(1, `FEXP_W'(1));
    run_one(2, `FEXP_W'(2));
    run_one(3, `FEXP_W'(`FEXP_P - 1));

    // Back to back, each start right after the previous o_done
    for (int i = 0; i < N_RANDOM; i++) begin
      xv = `FEXP_W'(1 + ($unsigned($random(seed)) % (`FEXP_P - 1)));
      run_one(N_FIXED + 1 + i, xv);
    end

    // Second strobe lands mid run
    target = done_cnt + 1;
    pulse_start(N_TESTS, 16'h1234);
    repeat (6) @(negedge clk);
    if (!busy) begin
      $display("ERROR: o_busy was low when the second strobe of busy_restart was issued");
      end_err++;
    end
    pulse_start(N_TESTS, 16'h4321);
    wait_done_count(target);

    // Quiet period to catch a stray o_done
    repeat (CYC_PER_TEST) @(negedge clk);
    if (pending != 0) begin
      $display("ERROR: %0d accepted runs never produced o_done", pending);
      end_err++;
    end
    if (done_cnt != N_TESTS) begin
      $display("ERROR: expected %0d o_done pulses but saw %0d", N_TESTS, done_cnt);
      end_err++;
    end

    $display("tests=%0d done=%0d errors=%0d timeouts=0", N_TESTS, done_cnt,
             err_cnt + end_err);
    if (err_cnt + end_err == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Run length limit
  always @(posedge clk) begin
    if (rst) begin
      cycle_cnt = 0;
    end else begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYC) begin
        $display("ERROR: o_done never arrived, run stopped after %0d cycles", cycle_cnt);
        $display("tests=%0d done=%0d errors=%0d timeouts=1", N_TESTS, done_cnt,
                 err_cnt + end_err);
        $display("Simulation failed");
        $finish;
      end
    end
  end

endmodule

/* tests/tb_checker.sv */
`include "fexp_defines.svh"

module tb_checker (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_start,
  input  logic [`FEXP_W-1:0] i_x,
  input  int                 i_test_id,
  input  logic               i_busy,
  input  logic               i_done,
  input  logic [`FEXP_W-1:0] i_y,
  output int                 o_err_cnt,
  output int                 o_done_cnt,
  output int                 o_pending
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_LAT = 80;

  logic [`FEXP_W-1:0] exp_q [$];
  int                 id_q [$];
  int                 t0_q [$];
  int                 cycle;
  logic               started;
  logic               busy_due;

  function automatic logic [`FEXP_W-1:0] mod_mul(input logic [`FEXP_W-1:0] a,
                                                 input logic [`FEXP_W-1:0] b);
    logic [63:0] prod;
    prod = 64'(a) * 64'(b);
    return `FEXP_W'(prod % `FEXP_P);
  endfunction

  // Right to left square and multiply
  function automatic logic [`FEXP_W-1:0] mod_pow(input logic [`FEXP_W-1:0] base,
                                                 input logic [`FEXP_W-1:0] e);
    logic [`FEXP_W-1:0] r;
    logic [`FEXP_W-1:0] b;
    logic [`FEXP_W-1:0] k;
    r = `FEXP_W'(1);
    b = mod_mul(base, `FEXP_W'(1));
    k = e;
    while (k != '0) begin
      if (k[0])
        r = mod_mul(r, b);
      b = mod_mul(b, b);
      k = k >> 1;
    end
    return r;
  endfunction

  // Runs the whole program one step after the other
  function automatic logic [`FEXP_W-1:0] fexp_ref(input logic [`FEXP_W-1:0] xv);
    logic [`FEXP_W-1:0] s1, s2, s3, s4, s5, s6;
    s1 = mod_pow(xv, `FEXP_X);
    s2 = mod_mul(xv, xv);
    s3 = mod_mul(s1, s2);
    s4 = mod_pow(s1, `FEXP_W'(`FEXP_P - 2));
    s5 = mod_pow(s3, `FEXP_X);
    s6 = mod_mul(s4, s5);
    return mod_mul(s6, s2);
  endfunction

  function automatic string test_label(input int id);
    case (id)
      1:       return "fixed_x1";
      2:       return "fixed_x2";
      3:       return "fixed_x65520";
      44:      return "busy_restart";
      default: return $sformatf("random_%0d", id - 3);
    endcase
  endfunction

  always @(posedge i_clk) begin : compare
    logic [`FEXP_W-1:0] want;
    int                 id;
    int                 t0;
    if (i_rst) begin
      cycle    = 0;
      started  = 1'b0;
      busy_due = 1'b0;
    end else begin
      cycle = cycle + 1;
      if (!started && i_busy) begin
        $display("ERROR: o_busy high before the first start, cycle %0d", cycle);
        o_err_cnt++;
      end
      if (busy_due && !i_busy) begin
        $display("ERROR: o_busy did not rise after an accepted start, cycle %0d", cycle);
        o_err_cnt++;
      end
      // A run in progress keeps o_busy high until its o_done
      if (!busy_due && exp_q.size() != 0 && !i_done && !i_busy) begin
        $display("ERROR: o_busy fell before o_done of the running test, cycle %0d", cycle);
        o_err_cnt++;
      end
      busy_due = 1'b0;
      if (i_done) begin
        o_done_cnt++;
        if (i_busy) begin
          $display("ERROR: o_busy still high while o_done pulses, cycle %0d", cycle);
          o_err_cnt++;
        end
        if (exp_q.size() == 0) begin
          $display("ERROR: o_done pulsed with no run in progress, cycle %0d", cycle);
          o_err_cnt++;
        end else begin
          want = exp_q.pop_front();
          id   = id_q.pop_front();
          t0   = t0_q.pop_front();
          if (i_y !== want) begin
            $display("ERROR %s expected %h actual %h", test_label(id), want, i_y);
            o_err_cnt++;
          end
          if (cycle - t0 > MAX_LAT) begin
            $display("ERROR: %s took %0d cycles from start to o_done", test_label(id),
                     cycle - t0);
            o_err_cnt++;
          end
        end
      end
      // Start is taken only while idle
      if (i_start && !i_busy) begin
        exp_q.push_back(fexp_ref(i_x));
        id_q.push_back(i_test_id);
        t0_q.push_back(cycle);
        started  = 1'b1;
        busy_due = 1'b1;
      end
      o_pending = exp_q.size();
    end
  end

endmodule

/* tests/tb_clkgen.sv */
module tb_clkgen (
  output logic o_clk,
  output logic o_rst
);
  timeunit 1ns;
  timeprecision 1ps;

  // 4 ns period
  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;
  end

  // Reset covers two rising edges, released on a falling edge
  initial begin
    o_rst = 1'b1;
    repeat (2) @(posedge o_clk);
    @(negedge o_clk);
    o_rst = 1'b0;
  end

endmodule

/* verilog/fexp_top.sv */
`include "fexp_defines.svh"

module fexp_top (
  input  logic           i_clk,
  input  logic           i_rst,
  input  logic           i_start,
  input  field_pkg::fe_t i_x,
  output logic           o_busy,
  output logic           o_done,
  output field_pkg::fe_t o_y
);

  field_pkg::mul_req_t    mul_req;
  field_pkg::pow_req_t    pow_req;
  field_pkg::unit_rsp_t   mul_rsp, pow_rsp;
  logic                   pow_idle;
  prog_pkg::slot_t        rd_a, rd_b;
  field_pkg::fe_t         val_a, val_b;
  logic [`FEXP_NSLOT-1:0] done_map;

  fexp_sched u_sched (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_start      (i_start),
    .i_done_map   (done_map),
    .i_pow_idle   (pow_idle),
    .i_slot_val_a (val_a),
    .i_slot_val_b (val_b),
    .o_slot_rd_a  (rd_a),
    .o_slot_rd_b  (rd_b),
    .o_mul_req    (mul_req),
    .o_pow_req    (pow_req),
    .o_busy       (o_busy)
  );

  fexp_mul_unit u_mul (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_req (mul_req),
    .o_rsp (mul_rsp)
  );

  fexp_pow_unit u_pow (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_req  (pow_req),
    .o_idle (pow_idle),
    .o_rsp  (pow_rsp)
  );

  fexp_slots u_slots (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_start    (i_start),
    .i_x        (i_x),
    .i_mul_rsp  (mul_rsp),
    .i_pow_rsp  (pow_rsp),
    .i_rd_a     (rd_a),
    .i_rd_b     (rd_b),
    .o_val_a    (val_a),
    .o_val_b    (val_b),
    .o_done_map (done_map),
    .o_done     (o_done),
    .o_y        (o_y)
  );

endmodule

/* verilog/fexp_slots.sv */
`include "fexp_defines.svh"

module fexp_slots (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_start,
  input  field_pkg::fe_t         i_x,
  input  field_pkg::unit_rsp_t   i_mul_rsp,
  input  field_pkg::unit_rsp_t   i_pow_rsp,
  input  prog_pkg::slot_t        i_rd_a,
  input  prog_pkg::slot_t        i_rd_b,
  output field_pkg::fe_t         o_val_a,
  output field_pkg::fe_t         o_val_b,
  output logic [`FEXP_NSLOT-1:0] o_done_map,
  output logic                   o_done,
  output field_pkg::fe_t         o_y
);

  field_pkg::fe_t         slot_q [`FEXP_NSLOT];
  logic [`FEXP_NSLOT-1:0] done_q;
  logic                   run_active;
  logic                   load;
  logic                   mul_last, pow_last;

  // Input loaded and last slot still empty
  assign run_active = done_q[0] && !done_q[`FEXP_NSLOT-1];
  assign load       = i_start && !run_active;
  assign mul_last   = i_mul_rsp.valid && i_mul_rsp.tag == field_pkg::tag_t'(`FEXP_NSTEP);
  assign pow_last   = i_pow_rsp.valid && i_pow_rsp.tag == field_pkg::tag_t'(`FEXP_NSTEP);

  assign o_val_a    = slot_q[i_rd_a];
  assign o_val_b    = slot_q[i_rd_b];
  assign o_done_map = done_q;

  always_ff @(posedge i_clk) begin
    if (load)
      slot_q[0] <= i_x;
    if (i_mul_rsp.valid)
      slot_q[i_mul_rsp.tag] <= i_mul_rsp.value;
    if (i_pow_rsp.valid)
      slot_q[i_pow_rsp.tag] <= i_pow_rsp.value;
    o_y <= mul_last ? i_mul_rsp.value : i_pow_rsp.value;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      done_q <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= mul_last || pow_last;
      if (load) begin
        done_q <= `FEXP_NSLOT'(1);
      end else begin
        if (i_mul_rsp.valid)
          done_q[i_mul_rsp.tag] <= 1'b1;
        if (i_pow_rsp.valid)
          done_q[i_pow_rsp.tag] <= 1'b1;
      end
    end
  end

  // Every slot is written once per run
  a_mul_fresh: assert property (@(posedge i_clk) disable iff (i_rst)
    i_mul_rsp.valid |-> !done_q[i_mul_rsp.tag]);
  a_pow_fresh: assert property (@(posedge i_clk) disable iff (i_rst)
    i_pow_rsp.valid |-> !done_q[i_pow_rsp.tag]);

endmodule

/* verilog/fexp_pow_unit.sv */
`include "fexp_defines.svh"

module fexp_pow_unit (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  field_pkg::pow_req_t  i_req,
  output logic                 o_idle,
  output field_pkg::unit_rsp_t o_rsp
);

  logic                         busy_q;
  logic [$clog2(`FEXP_W)-1:0]   bit_cnt;
  field_pkg::fe_t               acc_q, base_q;
  logic [`FEXP_W-1:0]           exp_q;
  field_pkg::tag_t              tag_q;
  logic [2*`FEXP_W-1:0]         sq_full, mul_full;
  field_pkg::fe_t               sq_red, acc_next;

  assign o_idle = !busy_q;

  // One exponent bit per cycle, MSB first
  always_comb begin
    sq_full  = acc_q * acc_q;
    sq_red   = field_pkg::fe_t'(sq_full % `FEXP_P);
    mul_full = sq_red * base_q;
    acc_next = exp_q[`FEXP_W-1] ? field_pkg::fe_t'(mul_full % `FEXP_P) : sq_red;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy_q      <= 1'b0;
      bit_cnt     <= '0;
      o_rsp.valid <= 1'b0;
    end else begin
      o_rsp.valid <= 1'b0;
      if (i_req.valid && !busy_q) begin
        // Load cycle
        busy_q  <= 1'b1;
        bit_cnt <= '0;
        acc_q   <= field_pkg::fe_t'(1);
        base_q  <= i_req.base;
        exp_q   <= i_req.exponent;
        tag_q   <= i_req.tag;
      end else if (busy_q) begin
        acc_q   <= acc_next;
        exp_q   <= exp_q << 1;
        bit_cnt <= bit_cnt + 1'b1;
        // Last bit, hand the result out directly
        if (&bit_cnt) begin
          busy_q      <= 1'b0;
          o_rsp.valid <= 1'b1;
          o_rsp.tag   <= tag_q;
          o_rsp.value <= acc_next;
        end
      end
    end
  end

  a_no_req_busy: assert property (@(posedge i_clk) disable iff (i_rst)
    i_req.valid |-> !busy_q);

endmodule

/* verilog/fexp_mul_unit.sv */
`include "fexp_defines.svh"

module fexp_mul_unit (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  field_pkg::mul_req_t  i_req,
  output field_pkg::unit_rsp_t o_rsp
);

  logic                   s1_valid;
  field_pkg::tag_t        s1_tag;
  logic [2*`FEXP_W-1:0]   s1_prod;
  logic [2*`FEXP_W-1:0]   s2_rem;

  // Reduction of the registered product
  assign s2_rem = s1_prod % `FEXP_P;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_valid    <= 1'b0;
      o_rsp.valid <= 1'b0;
    end else begin
      // Stage 1 full product
      s1_valid <= i_req.valid;
      s1_tag   <= i_req.tag;
      s1_prod  <= i_req.a * i_req.b;

      // Stage 2 reduced result
      o_rsp.valid <= s1_valid;
      o_rsp.tag   <= s1_tag;
      o_rsp.value <= s2_rem[`FEXP_W-1:0];
    end
  end

endmodule

/* verilog/fexp_sched.sv */
`include "fexp_defines.svh"

module fexp_sched (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic                        i_start,
  input  logic [`FEXP_NSLOT-1:0]      i_done_map,
  input  logic                        i_pow_idle,
  input  field_pkg::fe_t              i_slot_val_a,
  input  field_pkg::fe_t              i_slot_val_b,
  output prog_pkg::slot_t             o_slot_rd_a,
  output prog_pkg::slot_t             o_slot_rd_b,
  output field_pkg::mul_req_t         o_mul_req,
  output field_pkg::pow_req_t         o_pow_req,
  output logic                        o_busy
);

  logic [`FEXP_NSLOT-1:0] issued_q;
  logic [`FEXP_NSLOT-1:0] ready;
  logic                   busy_q;
  logic                   pow_free;
  logic                   mul_hit, pow_hit, pow_go;
  field_pkg::tag_t        mul_step, pow_step;
  prog_pkg::step_t        mul_op, pow_op;

  assign o_busy   = busy_q && !i_done_map[`FEXP_NSTEP];
  // Unit has not seen the request still sitting on the port
  assign pow_free = i_pow_idle && !o_pow_req.valid;

  // Sources done and step not yet issued
  always_comb begin
    ready = '0;
    for (int k = 1; k <= `FEXP_NSTEP; k++) begin
      ready[k] = o_busy && !issued_q[k] && i_done_map[prog_pkg::PROGRAM[k].src_a] &&
                 (prog_pkg::PROGRAM[k].op == prog_pkg::OP_POW ||
                  i_done_map[prog_pkg::PROGRAM[k].src_b]);
    end
  end

  // Scan from the top so the lowest ready step wins
  always_comb begin
    mul_hit  = 1'b0;
    pow_hit  = 1'b0;
    mul_step = field_pkg::tag_t'(1);
    pow_step = field_pkg::tag_t'(1);
    for (int k = `FEXP_NSTEP; k >= 1; k--) begin
      if (ready[k] && prog_pkg::PROGRAM[k].op == prog_pkg::OP_MUL) begin
        mul_hit  = 1'b1;
        mul_step = field_pkg::tag_t'(k);
      end
      if (ready[k] && prog_pkg::PROGRAM[k].op == prog_pkg::OP_POW && pow_free) begin
        pow_hit  = 1'b1;
        pow_step = field_pkg::tag_t'(k);
      end
    end
  end

  assign mul_op = prog_pkg::PROGRAM[mul_step];
  assign pow_op = prog_pkg::PROGRAM[pow_step];

  // Two read ports only
  // With a multiply going out, the power step must share one of its sources
  assign pow_go = pow_hit &&
                  (!mul_hit || pow_op.src_a == mul_op.src_a || pow_op.src_a == mul_op.src_b);

  assign o_slot_rd_a = mul_hit ? mul_op.src_a : pow_op.src_a;
  assign o_slot_rd_b = mul_op.src_b;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy_q          <= 1'b0;
      issued_q        <= '0;
      o_mul_req.valid <= 1'b0;
      o_pow_req.valid <= 1'b0;
    end else begin
      o_mul_req.valid <= mul_hit;
      o_mul_req.tag   <= mul_step;
      o_mul_req.a     <= i_slot_val_a;
      o_mul_req.b     <= i_slot_val_b;

      o_pow_req.valid    <= pow_go;
      o_pow_req.tag      <= pow_step;
      o_pow_req.base     <= (!mul_hit || pow_op.src_a == mul_op.src_a) ?
                            i_slot_val_a : i_slot_val_b;
      o_pow_req.exponent <= pow_op.exp_sel ? `FEXP_W'(`FEXP_P - 2) : `FEXP_X;

      if (i_start && !o_busy) begin
        busy_q   <= 1'b1;
        issued_q <= '0;
      end else begin
        if (i_done_map[`FEXP_NSTEP])
          busy_q <= 1'b0;
        if (mul_hit)
          issued_q[mul_step] <= 1'b1;
        if (pow_go)
          issued_q[pow_step] <= 1'b1;
      end
    end
  end

  // A step never goes out again once its result has landed in the slot bank
  a_mul_once: assert property (@(posedge i_clk) disable iff (i_rst)
    o_mul_req.valid |-> !i_done_map[o_mul_req.tag]);
  a_pow_once: assert property (@(posedge i_clk) disable iff (i_rst)
    o_pow_req.valid |-> !i_done_map[o_pow_req.tag]);

  a_pow_idle: assert property (@(posedge i_clk) disable iff (i_rst)
    o_pow_req.valid |-> i_pow_idle);

endmodule

/* verilog/prog_pkg.sv */
`include "fexp_defines.svh"

package prog_pkg;

  typedef enum logic {
    OP_MUL = 1'b0,
    OP_POW = 1'b1
  } op_e;

  // Index into the slot bank
  typedef logic [$clog2(`FEXP_NSLOT)-1:0] slot_t;

  // One program step
  // exp_sel picks X (0) or P-2 (1), src_b is ignored by POW
  typedef struct packed {
    op_e   op;
    slot_t dst;
    slot_t src_a;
    slot_t src_b;
    logic  exp_sel;
  } step_t;

  // Step k writes slot k
  localparam step_t PROGRAM [1:`FEXP_NSTEP] = '{
    '{OP_POW, 3'd1, 3'd0, 3'd0, 1'b0},
    '{OP_MUL, 3'd2, 3'd0, 3'd0, 1'b0},
    '{OP_MUL, 3'd3, 3'd1, 3'd2, 1'b0},
    // Inversion of s1 by Fermat
    '{OP_POW, 3'd4, 3'd1, 3'd0, 1'b1},
    '{OP_POW, 3'd5, 3'd3, 3'd0, 1'b0},
    '{OP_MUL, 3'd6, 3'd4, 3'd5, 1'b0},
    '{OP_MUL, 3'd7, 3'd6, 3'd2, 1'b0}
  };

endpackage

/* verilog/field_pkg.sv */
`include "fexp_defines.svh"

package field_pkg;

  // One element of GF(P)
  typedef logic [`FEXP_W-1:0] fe_t;

  // Step number carried with a request and written back as the slot index
  typedef logic [2:0] tag_t;

  // Multiplier request, one cycle wide
  typedef struct packed {
    logic valid;
    tag_t tag;
    fe_t  a;
    fe_t  b;
  } mul_req_t;

  // Power unit request
  typedef struct packed {
    logic              valid;
    tag_t              tag;
    fe_t               base;
    logic [`FEXP_W-1:0] exponent;
  } pow_req_t;

  // Result of either unit
  typedef struct packed {
    logic valid;
    tag_t tag;
    fe_t  value;
  } unit_rsp_t;

endpackage

/* verilog/fexp_defines.svh */
`ifndef FEXP_DEFINES_SVH
`define FEXP_DEFINES_SVH

// Element width in bits
`define FEXP_W 16

// Prime modulus of the field
`define FEXP_P 65521

// Exponent used by the two power steps that are not inversions
`define FEXP_X 16'h00d1

// Temporary slots, s0 holds the input
`define FEXP_NSLOT 8

// Program length
// Steps count from 1, so bitmaps are FEXP_NSTEP+1 wide and bit 0 belongs to s0
`define FEXP_NSTEP 7

`endif
